//--- cfg_dispatch_config.svh
/*
  configuration dispatcher constants
  word widths, header marker, header field positions
  and the unpack counter limits
*/
`ifndef CFG_DISPATCH_CONFIG_SVH
`define CFG_DISPATCH_CONFIG_SVH

// word widths
`define CFG_WORD_W        32
`define RS_WORD_W         64
`define CFG_ADDR_W        8

// header word layout
`define CFG_HDR_MARK      16'hABAB
`define HDR_MARK_MSB      31
`define HDR_MARK_LSB      16
`define HDR_SEL_MSB       15
`define HDR_SEL_LSB       8
`define HDR_ADDR_MSB      7
`define HDR_ADDR_LSB      0

// unpack counter, runs 0..UNPACK_LAST while the unpack enable is set
`define UNPACK_CNT_W      3
`define UNPACK_HDR_CNT    3'd0
`define UNPACK_DATA_CNT   3'd1
`define UNPACK_RDY_CNT    3'd2
`define UNPACK_START_CNT  3'd3
`define UNPACK_LAST       3'd5

`endif

//--- cfg_dispatch_pkg.sv
/*
  configuration dispatcher types
  config word, register address and the device select opcode
*/
`include "cfg_dispatch_config.svh"

package cfg_dispatch_pkg;

  // one command word, header or data
  typedef logic [`CFG_WORD_W-1:0] cfg_word_t;

  // device register address from header bits 7:0
  typedef logic [`CFG_ADDR_W-1:0] cfg_addr_t;

  // device select from header bits 15:8
  // values above 7 are unmapped and routed nowhere
  typedef enum logic [7:0] {
    DEV_NONE    = 8'd0,
    DEV_LMK0    = 8'd1,
    DEV_LMK1    = 8'd2,
    DEV_DAC     = 8'd3,
    DEV_ADC0    = 8'd4,
    DEV_ADC1    = 8'd5,
    DEV_ADF4351 = 8'd6,
    DEV_ADS8332 = 8'd7
  } dev_sel_e;

endpackage

//--- cfg_cmd_if.sv
/*
  unpacked command bus
  carries select, address and data from the packet unpacker
  to the device router and the SPI start controller
*/
`timescale 1ns/100ps

interface cfg_cmd_if
  import cfg_dispatch_pkg::*;
();

  dev_sel_e  sel;
  cfg_addr_t addr;
  cfg_word_t data;
  // level, four cycles per accepted command
  logic      data_rdy;
  // single-cycle SPI start request
  logic      start_evt;

  modport source (output sel, output addr, output data, output data_rdy, output start_evt);

  modport route (input sel, input addr, input data, input data_rdy);

  modport start (input sel, input start_evt);

endinterface

//--- rs_word_splitter.sv
/*
  host word splitter
  one 64-bit host word becomes two back-to-back 32-bit words,
  high half first, with valid over both cycles
*/
`timescale 1ns/100ps
`include "cfg_dispatch_config.svh"

module rs_word_splitter
  import cfg_dispatch_pkg::*;
(
  input  logic                  spi_clk_in,
  input  logic                  sys_rest,
  input  logic                  rs_rx_data_valid,
  input  logic [`RS_WORD_W-1:0] rs_rx_data,
  output cfg_word_t             rs_word,
  output logic                  rs_word_valid
);

  logic [`RS_WORD_W-1:0] rs_hold;
  logic                  rs_valid_d1;
  logic                  rs_valid_d2;

  // host word held while its halves go out
  always_ff @(posedge spi_clk_in) begin
    if (rs_rx_data_valid) begin
      rs_hold <= rs_rx_data;
    end
  end

  // two-stage valid delay, d1 selects high half, d2 low half
  always_ff @(posedge spi_clk_in or posedge sys_rest) begin
    if (sys_rest) begin
      rs_valid_d1 <= 1'b0;
      rs_valid_d2 <= 1'b0;
    end else begin
      rs_valid_d1 <= rs_rx_data_valid;
      rs_valid_d2 <= rs_valid_d1;
    end
  end

  // registered half select, zero word when idle
  always_ff @(posedge spi_clk_in or posedge sys_rest) begin
    if (sys_rest) begin
      rs_word       <= '0;
      rs_word_valid <= 1'b0;
    end else begin
      rs_word_valid <= rs_valid_d1 | rs_valid_d2;
      if (rs_valid_d1) begin
        rs_word <= rs_hold[`RS_WORD_W-1:`CFG_WORD_W];
      end else if (rs_valid_d2) begin
        rs_word <= rs_hold[`CFG_WORD_W-1:0];
      end else begin
        rs_word <= '0;
      end
    end
  end

endmodule

//--- cfg_source_arbiter.sv
/*
  command source merge
  host words win over McBSP words, a McBSP word that
  collides with a host word is dropped
*/
`timescale 1ns/100ps

module cfg_source_arbiter
  import cfg_dispatch_pkg::*;
(
  input  logic      spi_clk_in,
  input  logic      sys_rest,
  input  cfg_word_t rs_word,
  input  logic      rs_word_valid,
  input  cfg_word_t mcbsp_data,
  input  logic      mcbsp_data_valid,
  output cfg_word_t cfg_data,
  output logic      cfg_data_valid
);

  // one register stage for both sources
  always_ff @(posedge spi_clk_in or posedge sys_rest) begin
    if (sys_rest) begin
      cfg_data       <= '0;
      cfg_data_valid <= 1'b0;
    end else if (rs_word_valid) begin
      // host link first
      cfg_data       <= rs_word;
      cfg_data_valid <= 1'b1;
    end else if (mcbsp_data_valid) begin
      cfg_data       <= mcbsp_data;
      cfg_data_valid <= 1'b1;
    end else begin
      // idle bus reads as zero
      cfg_data       <= '0;
      cfg_data_valid <= 1'b0;
    end
  end

endmodule

//--- cfg_packet_unpacker.sv
/*
  command packet unpacker
  finds a marked header on the rising edge of valid, then runs
  a short counter that captures select, address and data and
  times the data ready level and the SPI start event
*/
`timescale 1ns/100ps
`include "cfg_dispatch_config.svh"

module cfg_packet_unpacker
  import cfg_dispatch_pkg::*;
(
  input  logic      spi_clk_in,
  input  logic      sys_rest,
  input  cfg_word_t cfg_data,
  input  logic      cfg_data_valid,
  cfg_cmd_if.source cmd
);

  cfg_word_t                cfg_data_dl;
  logic                     cfg_valid_dl;
  logic                     hdr_hit;
  logic                     unpack_en;
  logic [`UNPACK_CNT_W-1:0] unpack_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // header detect

  // word delay, header sits here at count 0, data word at count 1
  always_ff @(posedge spi_clk_in) begin
    cfg_data_dl <= cfg_data;
  end

  always_ff @(posedge spi_clk_in or posedge sys_rest) begin
    if (sys_rest) begin
      cfg_valid_dl <= 1'b0;
    end else begin
      cfg_valid_dl <= cfg_data_valid;
    end
  end

  // first word of a burst with the marker in the top half
  assign hdr_hit = cfg_data_valid && !cfg_valid_dl &&
                   (cfg_data[`HDR_MARK_MSB:`HDR_MARK_LSB] == `CFG_HDR_MARK);

  ////////////////////////////////////////////////////////////////////////////
  // unpack enable and counter

  always_ff @(posedge spi_clk_in or posedge sys_rest) begin
    if (sys_rest) begin
      unpack_en <= 1'b0;
    end else if (unpack_en && unpack_cnt == `UNPACK_LAST) begin
      unpack_en <= 1'b0;
    end else if (hdr_hit) begin
      unpack_en <= 1'b1;
    end
  end

  // counts 0..last while enabled, back to 0 with the enable
  always_ff @(posedge spi_clk_in or posedge sys_rest) begin
    if (sys_rest) begin
      unpack_cnt <= '0;
    end else if (unpack_en && unpack_cnt != `UNPACK_LAST) begin
      unpack_cnt <= unpack_cnt + 1'b1;
    end else begin
      unpack_cnt <= '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // field capture

  always_ff @(posedge spi_clk_in or posedge sys_rest) begin
    if (sys_rest) begin
      cmd.sel  <= DEV_NONE;
      cmd.addr <= '0;
      cmd.data <= '0;
    end else if (unpack_en) begin
      // select and address from the header
      if (unpack_cnt == `UNPACK_HDR_CNT) begin
        cmd.sel  <= dev_sel_e'(cfg_data_dl[`HDR_SEL_MSB:`HDR_SEL_LSB]);
        cmd.addr <= cfg_data_dl[`HDR_ADDR_MSB:`HDR_ADDR_LSB];
      end
      // payload from the word after the header
      if (unpack_cnt == `UNPACK_DATA_CNT) begin
        cmd.data <= cfg_data_dl;
      end
    end
  end

  // ready over counts 2..5, four cycles
  always_ff @(posedge spi_clk_in or posedge sys_rest) begin
    if (sys_rest) begin
      cmd.data_rdy <= 1'b0;
    end else begin
      cmd.data_rdy <= unpack_en && (unpack_cnt >= `UNPACK_RDY_CNT);
    end
  end

  // one cycle at count 3, registered by the start controller
  assign cmd.start_evt = unpack_en && (unpack_cnt == `UNPACK_START_CNT);

endmodule

//--- cfg_device_router.sv
/*
  device configuration router
  steers the unpacked command to the DAC, ADC, LMK or
  IF-to-RF channel by device select, and drives the RF
  select mode level
*/
`timescale 1ns/100ps

module cfg_device_router
  import cfg_dispatch_pkg::*;
(
  input  logic      spi_clk_in,
  input  logic      sys_rest,
  cfg_cmd_if.route  cmd,
  output cfg_word_t dac_cfg_data,
  output cfg_addr_t dac_cfg_addr,
  output logic      dac_cfg_valid,
  output cfg_word_t adc_cfg_data,
  output cfg_addr_t adc_cfg_addr,
  output logic      adc_cfg_valid,
  output cfg_word_t if2rf_cfg_wr_data,
  output cfg_addr_t if2rf_cfg_addr,
  output logic      if2rf_cfg_valid,
  output cfg_word_t lmk_cfg_data,
  output cfg_addr_t lmk_cfg_addr,
  output logic      lmk_cfg_valid,
  output logic      if2rf_cfg_select_mode
);

  // selected channel follows data_rdy, the rest hold
  always_ff @(posedge spi_clk_in or posedge sys_rest) begin
    if (sys_rest) begin
      dac_cfg_data      <= '0;
      dac_cfg_addr      <= '0;
      dac_cfg_valid     <= 1'b0;
      adc_cfg_data      <= '0;
      adc_cfg_addr      <= '0;
      adc_cfg_valid     <= 1'b0;
      if2rf_cfg_wr_data <= '0;
      if2rf_cfg_addr    <= '0;
      if2rf_cfg_valid   <= 1'b0;
      lmk_cfg_data      <= '0;
      lmk_cfg_addr      <= '0;
      lmk_cfg_valid     <= 1'b0;
    end else begin
      case (cmd.sel)
        DEV_ADC0, DEV_ADC1: begin
          adc_cfg_valid <= cmd.data_rdy;
          if (cmd.data_rdy) begin
            adc_cfg_data <= cmd.data;
            adc_cfg_addr <= cmd.addr;
          end
        end
        DEV_LMK0, DEV_LMK1: begin
          lmk_cfg_valid <= cmd.data_rdy;
          if (cmd.data_rdy) begin
            lmk_cfg_data <= cmd.data;
            lmk_cfg_addr <= cmd.addr;
          end
        end
        DEV_DAC: begin
          dac_cfg_valid <= cmd.data_rdy;
          if (cmd.data_rdy) begin
            dac_cfg_data <= cmd.data;
            dac_cfg_addr <= cmd.addr;
          end
        end
        // both RF parts share the IF-to-RF SPI channel
        DEV_ADF4351, DEV_ADS8332: begin
          if2rf_cfg_valid <= cmd.data_rdy;
          if (cmd.data_rdy) begin
            if2rf_cfg_wr_data <= cmd.data;
            if2rf_cfg_addr    <= cmd.addr;
          end
        end
        // none and unmapped selects touch nothing
        default: begin
        end
      endcase
    end
  end

  // high for ADS8332, low for ADF4351 and everything else
  always_ff @(posedge spi_clk_in or posedge sys_rest) begin
    if (sys_rest) begin
      if2rf_cfg_select_mode <= 1'b0;
    end else begin
      if2rf_cfg_select_mode <= (cmd.sel == DEV_ADS8332);
    end
  end

endmodule

//--- spi_start_ctrl.sv
/*
  SPI start pulse generator
  init request drives the LMK pair, a DSP ready pulse drives
  the ADCs and the ADF4351, otherwise a command start event
  drives the one device named by the select
*/
`timescale 1ns/100ps

module spi_start_ctrl
  import cfg_dispatch_pkg::*;
(
  input  logic     spi_clk_in,
  input  logic     sys_rest,
  cfg_cmd_if.start cmd,
  input  logic     initial_en,
  input  logic     spi_initial_start,
  input  logic     dsp_rdy_pulse,
  output logic     lmk0_spi_start,
  output logic     lmk1_spi_start,
  output logic     dac_spi_start,
  output logic     adc0_spi_start,
  output logic     adc1_spi_start,
  output logic     adf4351_spi_start,
  output logic     ads8332_spi_start
);

  // bit n is the start of select n+1
  logic [6:0] start_nxt;
  logic [6:0] start_q;

  always_comb begin
    start_nxt = '0;
    if (initial_en) begin
      // power-up init, LMK pair only
      start_nxt[0] = spi_initial_start;
      start_nxt[1] = spi_initial_start;
    end else if (dsp_rdy_pulse) begin
      // adc0, adc1, adf4351
      start_nxt[3] = 1'b1;
      start_nxt[4] = 1'b1;
      start_nxt[5] = 1'b1;
    end else if (cmd.start_evt) begin
      case (cmd.sel)
        DEV_LMK0:    start_nxt[0] = 1'b1;
        DEV_LMK1:    start_nxt[1] = 1'b1;
        DEV_DAC:     start_nxt[2] = 1'b1;
        DEV_ADC0:    start_nxt[3] = 1'b1;
        DEV_ADC1:    start_nxt[4] = 1'b1;
        DEV_ADF4351: start_nxt[5] = 1'b1;
        DEV_ADS8332: start_nxt[6] = 1'b1;
        default:     start_nxt    = '0;
      endcase
    end
  end

  always_ff @(posedge spi_clk_in or posedge sys_rest) begin
    if (sys_rest) begin
      start_q <= '0;
    end else begin
      start_q <= start_nxt;
    end
  end

  assign lmk0_spi_start    = start_q[0];
  assign lmk1_spi_start    = start_q[1];
  assign dac_spi_start     = start_q[2];
  assign adc0_spi_start    = start_q[3];
  assign adc1_spi_start    = start_q[4];
  assign adf4351_spi_start = start_q[5];
  assign ads8332_spi_start = start_q[6];

endmodule

//--- device_wr_process.sv
/*
  device write dispatcher top level
  host link and McBSP commands in, per-device configuration
  channels and SPI start strobes out, all on spi_clk_in
*/
`timescale 1ns/100ps
`include "cfg_dispatch_config.svh"

module device_wr_process
  import cfg_dispatch_pkg::*;
(
  input  logic                  spi_clk_in,
  input  logic                  sys_rest,
  input  logic                  rs_rx_data_valid,
  input  logic [`RS_WORD_W-1:0] rs_rx_data,
  input  cfg_word_t             mcbsp_data,
  input  logic                  mcbsp_data_valid,
  input  logic                  dsp_rdy_pulse,
  input  logic                  initial_en,
  input  logic                  spi_initial_start,
  output cfg_word_t             dac_cfg_data,
  output cfg_addr_t             dac_cfg_addr,
  output logic                  dac_cfg_valid,
  output cfg_word_t             adc_cfg_data,
  output cfg_addr_t             adc_cfg_addr,
  output logic                  adc_cfg_valid,
  output cfg_word_t             if2rf_cfg_wr_data,
  output cfg_addr_t             if2rf_cfg_addr,
  output logic                  if2rf_cfg_valid,
  output cfg_word_t             lmk_cfg_data,
  output cfg_addr_t             lmk_cfg_addr,
  output logic                  lmk_cfg_valid,
  output logic                  lmk0_spi_start,
  output logic                  lmk1_spi_start,
  output logic                  adc0_spi_start,
  output logic                  adc1_spi_start,
  output logic                  dac_spi_start,
  output logic                  adf4351_spi_start,
  output logic                  ads8332_spi_start,
  output logic                  if2rf_cfg_select_mode,
  output logic                  spi_single_en
);

  cfg_word_t rs_word;
  logic      rs_word_valid;
  cfg_word_t cfg_data;
  logic      cfg_data_valid;

  cfg_cmd_if cmd_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // command path, host split then source merge then unpack

  rs_word_splitter u_rs_word_splitter (
    .spi_clk_in       (spi_clk_in),
    .sys_rest         (sys_rest),
    .rs_rx_data_valid (rs_rx_data_valid),
    .rs_rx_data       (rs_rx_data),
    .rs_word          (rs_word),
    .rs_word_valid    (rs_word_valid)
  );

  cfg_source_arbiter u_cfg_source_arbiter (
    .spi_clk_in       (spi_clk_in),
    .sys_rest         (sys_rest),
    .rs_word          (rs_word),
    .rs_word_valid    (rs_word_valid),
    .mcbsp_data       (mcbsp_data),
    .mcbsp_data_valid (mcbsp_data_valid),
    .cfg_data         (cfg_data),
    .cfg_data_valid   (cfg_data_valid)
  );

  cfg_packet_unpacker u_cfg_packet_unpacker (
    .spi_clk_in     (spi_clk_in),
    .sys_rest       (sys_rest),
    .cfg_data       (cfg_data),
    .cfg_data_valid (cfg_data_valid),
    .cmd            (cmd_bus.source)
  );

  ////////////////////////////////////////////////////////////////////////////
  // device side, channel routing and SPI starts

  cfg_device_router u_cfg_device_router (
    .spi_clk_in            (spi_clk_in),
    .sys_rest              (sys_rest),
    .cmd                   (cmd_bus.route),
    .dac_cfg_data          (dac_cfg_data),
    .dac_cfg_addr          (dac_cfg_addr),
    .dac_cfg_valid         (dac_cfg_valid),
    .adc_cfg_data          (adc_cfg_data),
    .adc_cfg_addr          (adc_cfg_addr),
    .adc_cfg_valid         (adc_cfg_valid),
    .if2rf_cfg_wr_data     (if2rf_cfg_wr_data),
    .if2rf_cfg_addr        (if2rf_cfg_addr),
    .if2rf_cfg_valid       (if2rf_cfg_valid),
    .lmk_cfg_data          (lmk_cfg_data),
    .lmk_cfg_addr          (lmk_cfg_addr),
    .lmk_cfg_valid         (lmk_cfg_valid),
    .if2rf_cfg_select_mode (if2rf_cfg_select_mode)
  );

  spi_start_ctrl u_spi_start_ctrl (
    .spi_clk_in        (spi_clk_in),
    .sys_rest          (sys_rest),
    .cmd               (cmd_bus.start),
    .initial_en        (initial_en),
    .spi_initial_start (spi_initial_start),
    .dsp_rdy_pulse     (dsp_rdy_pulse),
    .lmk0_spi_start    (lmk0_spi_start),
    .lmk1_spi_start    (lmk1_spi_start),
    .dac_spi_start     (dac_spi_start),
    .adc0_spi_start    (adc0_spi_start),
    .adc1_spi_start    (adc1_spi_start),
    .adf4351_spi_start (adf4351_spi_start),
    .ads8332_spi_start (ads8332_spi_start)
  );

  // single write enable is the data ready level itself
  assign spi_single_en = cmd_bus.data_rdy;

endmodule

//--- device_wr_process_properties.sv
/*
  device write dispatcher assertions
  single-cycle SPI starts, one channel valid at a time and
  a four-cycle single write enable
*/
`timescale 1ns/100ps

module device_wr_process_properties (
  input logic spi_clk_in,
  input logic sys_rest,
  input logic initial_en,
  input logic lmk0_spi_start,
  input logic lmk1_spi_start,
  input logic dac_spi_start,
  input logic adc0_spi_start,
  input logic adc1_spi_start,
  input logic adf4351_spi_start,
  input logic ads8332_spi_start,
  input logic dac_cfg_valid,
  input logic adc_cfg_valid,
  input logic if2rf_cfg_valid,
  input logic lmk_cfg_valid,
  input logic spi_single_en
);

  logic [6:0] starts;
  logic [2:0] en_run;

  // number of assertion failures so far
  int fail_cnt = 0;

  assign starts = {ads8332_spi_start, adf4351_spi_start, adc1_spi_start, adc0_spi_start,
                   dac_spi_start, lmk1_spi_start, lmk0_spi_start};

  // length of the current single_en run
  always_ff @(posedge spi_clk_in or posedge sys_rest) begin
    if (sys_rest) begin
      en_run <= '0;
    end else if (spi_single_en) begin
      en_run <= en_run + 3'd1;
    end else begin
      en_run <= '0;
    end
  end

  // no start high two cycles running outside init
  a_start_pulse: assert property (@(posedge spi_clk_in) disable iff (sys_rest)
    (|starts) && !initial_en |=> !(|(starts & $past(starts))))
    else begin
      $error("spi start held for more than one cycle");
      fail_cnt = fail_cnt + 1;
    end

  a_valid_onehot: assert property (@(posedge spi_clk_in) disable iff (sys_rest)
    $onehot0({dac_cfg_valid, adc_cfg_valid, if2rf_cfg_valid, lmk_cfg_valid}))
    else begin
      $error("more than one channel valid at once");
      fail_cnt = fail_cnt + 1;
    end

  a_single_en_max: assert property (@(posedge spi_clk_in) disable iff (sys_rest)
    spi_single_en |-> en_run < 3'd4)
    else begin
      $error("spi_single_en longer than four cycles");
      fail_cnt = fail_cnt + 1;
    end

  a_single_en_len: assert property (@(posedge spi_clk_in) disable iff (sys_rest)
    !spi_single_en && en_run != 3'd0 |-> en_run == 3'd4)
    else begin
      $error("spi_single_en shorter than four cycles");
      fail_cnt = fail_cnt + 1;
    end

endmodule

//--- device_wr_process_tb.sv
/*
  device write dispatcher testbench
  replays the command trace through the DUT and checks the
  channel valids, data and address, the SPI starts, the single
  write enable and the RF select mode cycle by cycle
*/
`timescale 1ns/100ps
`include "cfg_dispatch_config.svh"

module device_wr_process_tb
  import cfg_dispatch_pkg::*;
();

  localparam int kind_rs    = 0;
  localparam int kind_mcbsp = 1;
  localparam int kind_init  = 2;
  localparam int kind_dsp   = 3;

  logic                  spi_clk_in = 1'b0;
  logic                  sys_rest;
  logic                  rs_rx_data_valid;
  logic [`RS_WORD_W-1:0] rs_rx_data;
  cfg_word_t             mcbsp_data;
  logic                  mcbsp_data_valid;
  logic                  dsp_rdy_pulse;
  logic                  initial_en;
  logic                  spi_initial_start;
  cfg_word_t             dac_cfg_data, adc_cfg_data, if2rf_cfg_wr_data, lmk_cfg_data;
  cfg_addr_t             dac_cfg_addr, adc_cfg_addr, if2rf_cfg_addr, lmk_cfg_addr;
  logic                  dac_cfg_valid, adc_cfg_valid, if2rf_cfg_valid, lmk_cfg_valid;
  logic                  lmk0_spi_start, lmk1_spi_start, dac_spi_start;
  logic                  adc0_spi_start, adc1_spi_start;
  logic                  adf4351_spi_start, ads8332_spi_start;
  logic                  if2rf_cfg_select_mode;
  logic                  spi_single_en;

  // one entry per trace command line
  int         tr_kind[$];
  cfg_word_t  tr_hdr[$];
  cfg_word_t  tr_data[$];
  int         tr_clash[$];
  int         tr_chan[$];
  cfg_word_t  tr_exp_data[$];
  cfg_addr_t  tr_exp_addr[$];
  logic [6:0] tr_starts[$];
  logic       tr_mode[$];

  // last value written to each channel (1 lmk 2 dac 3 adc 4 if2rf)
  cfg_word_t  shadow_data[1:4];
  cfg_addr_t  shadow_addr[1:4];

  int cycle_cnt   = 0;
  int cycle_limit = 0;
  int cur_entry   = 0;
  int cur_k       = 0;

  always #20 spi_clk_in = ~spi_clk_in;

  device_wr_process u_device_wr_process (.*);

  bind device_wr_process device_wr_process_properties u_props (
    .spi_clk_in        (spi_clk_in),
    .sys_rest          (sys_rest),
    .initial_en        (initial_en),
    .lmk0_spi_start    (lmk0_spi_start),
    .lmk1_spi_start    (lmk1_spi_start),
    .dac_spi_start     (dac_spi_start),
    .adc0_spi_start    (adc0_spi_start),
    .adc1_spi_start    (adc1_spi_start),
    .adf4351_spi_start (adf4351_spi_start),
    .ads8332_spi_start (ads8332_spi_start),
    .dac_cfg_valid     (dac_cfg_valid),
    .adc_cfg_valid     (adc_cfg_valid),
    .if2rf_cfg_valid   (if2rf_cfg_valid),
    .lmk_cfg_valid     (lmk_cfg_valid),
    .spi_single_en     (spi_single_en)
  );

  // run limit of 16 cycles per trace entry plus reset
  always @(posedge spi_clk_in) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation did not finish in time");
    end
  end

  // bound pulse and valid rules on the DUT outputs
  always @(negedge spi_clk_in) begin
    if (u_device_wr_process.u_props.fail_cnt != 0) begin
      stop_run("a bound assertion on the DUT outputs failed");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first mismatch");
  endtask

  task automatic check_word(input string name, input cfg_word_t got, input cfg_word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("error: %s = %h, expected %h (entry %0d, cycle %0d)",
                         name, got, exp, cur_entry, cur_k));
    end
  endtask

  task automatic check_addr(input string name, input cfg_addr_t got, input cfg_addr_t exp);
    if (got !== exp) begin
      stop_run($sformatf("error: %s = %h, expected %h (entry %0d, cycle %0d)",
                         name, got, exp, cur_entry, cur_k));
    end
  endtask

  task automatic check_starts(input string name, input logic [6:0] got,
                              input logic [6:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("error: %s = %h, expected %h (entry %0d, cycle %0d)",
                         name, got, exp, cur_entry, cur_k));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("error: %s = %h, expected %h (entry %0d, cycle %0d)",
                         name, got, exp, cur_entry, cur_k));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // channel views

  // bit n-1 is the start of select n
  function automatic logic [6:0] starts_now();
    return {ads8332_spi_start, adf4351_spi_start, adc1_spi_start, adc0_spi_start,
            dac_spi_start, lmk1_spi_start, lmk0_spi_start};
  endfunction

  function automatic string chan_name(input int c);
    case (c)
      1:       return "lmk";
      2:       return "dac";
      3:       return "adc";
      default: return "if2rf";
    endcase
  endfunction

  function automatic logic chan_valid(input int c);
    case (c)
      1:       return lmk_cfg_valid;
      2:       return dac_cfg_valid;
      3:       return adc_cfg_valid;
      default: return if2rf_cfg_valid;
    endcase
  endfunction

  function automatic cfg_word_t chan_data(input int c);
    case (c)
      1:       return lmk_cfg_data;
      2:       return dac_cfg_data;
      3:       return adc_cfg_data;
      default: return if2rf_cfg_wr_data;
    endcase
  endfunction

  function automatic cfg_addr_t chan_addr(input int c);
    case (c)
      1:       return lmk_cfg_addr;
      2:       return dac_cfg_addr;
      3:       return adc_cfg_addr;
      default: return if2rf_cfg_addr;
    endcase
  endfunction

  // every channel holds its last written data and address
  task automatic check_channels();
    int c;
    for (c = 1; c <= 4; c++) begin
      check_word($sformatf("%s_cfg_data", chan_name(c)), chan_data(c), shadow_data[c]);
      check_addr($sformatf("%s_cfg_addr", chan_name(c)), chan_addr(c), shadow_addr[c]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // trace load

  task automatic load_trace();
    int            fd;
    int            n;
    string         line;
    logic [39:0]   kind_raw;
    int            kind;
    cfg_word_t     hdr, data, exp_data;
    int            clash, chan;
    cfg_addr_t     exp_addr;
    logic [6:0]    starts;
    logic          mode;
    fd = $fopen("device_wr_trace.txt", "r");
    if (fd == 0) begin
      stop_run("could not open the trace file device_wr_trace.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // skip comments and blank lines
      if (n > 0 && line.len() > 4 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", kind_raw, hdr, data, clash,
                    chan, exp_data, exp_addr, starts, mode);
        if (n != 9) begin
          stop_run($sformatf("trace line has %0d fields instead of 9: %s", n, line));
        end
        if (kind_raw == "rs") begin
          kind = kind_rs;
        end else if (kind_raw == "mcbsp") begin
          kind = kind_mcbsp;
        end else if (kind_raw == "init") begin
          kind = kind_init;
        end else if (kind_raw == "dsp") begin
          kind = kind_dsp;
        end else begin
          stop_run($sformatf("unknown command kind in trace line: %s", line));
        end
        tr_kind.push_back(kind);
        tr_hdr.push_back(hdr);
        tr_data.push_back(data);
        tr_clash.push_back(clash);
        tr_chan.push_back(chan);
        tr_exp_data.push_back(exp_data);
        tr_exp_addr.push_back(exp_addr);
        tr_starts.push_back(starts);
        tr_mode.push_back(mode);
      end
    end
    $fclose(fd);
    if (tr_kind.size() == 0) begin
      stop_run("trace file holds no commands");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // per-entry stimulus and checks
  // slot k is the falling edge after edge Ek

  task automatic drive_slot(input int i, input int k);
    rs_rx_data_valid  = 1'b0;
    mcbsp_data_valid  = 1'b0;
    mcbsp_data        = '0;
    initial_en        = 1'b0;
    spi_initial_start = 1'b0;
    dsp_rdy_pulse     = 1'b0;
    case (tr_kind[i])
      kind_rs: begin
        if (k == -1) begin
          rs_rx_data_valid = 1'b1;
          rs_rx_data       = {tr_hdr[i], tr_data[i]};
        end
      end
      kind_mcbsp: begin
        // empty host word so both McBSP words meet host halves
        if (k == -1 && tr_clash[i] != 0) begin
          rs_rx_data_valid = 1'b1;
          rs_rx_data       = '0;
        end
        if (k == 1) begin
          mcbsp_data_valid = 1'b1;
          mcbsp_data       = tr_hdr[i];
        end
        if (k == 2) begin
          mcbsp_data_valid = 1'b1;
          mcbsp_data       = tr_data[i];
        end
      end
      kind_init: begin
        if (k == -1) begin
          initial_en        = 1'b1;
          spi_initial_start = 1'b1;
        end
      end
      default: begin
        if (k == -1) begin
          dsp_rdy_pulse = 1'b1;
        end
      end
    endcase
  endtask

  task automatic check_slot(input int i, input int k);
    logic       marked;
    int         start_k;
    int         c;
    logic [6:0] exp_starts;
    // only a marked header on a clean bus starts an unpack
    marked = (tr_kind[i] == kind_rs || tr_kind[i] == kind_mcbsp) && tr_clash[i] == 0 &&
             tr_hdr[i][31:16] == `CFG_HDR_MARK;
    start_k = (tr_kind[i] == kind_init || tr_kind[i] == kind_dsp) ? 0 : 7;
    exp_starts = (k == start_k) ? tr_starts[i] : 7'h00;
    check_starts("spi_start", starts_now(), exp_starts);
    check_bit("spi_single_en", spi_single_en, marked && k >= 6 && k <= 9);
    for (c = 1; c <= 4; c++) begin
      check_bit($sformatf("%s_cfg_valid", chan_name(c)), chan_valid(c),
                tr_chan[i] == c && k >= 7 && k <= 10);
    end
    if (k == 7 && tr_chan[i] != 0) begin
      shadow_data[tr_chan[i]] = tr_exp_data[i];
      shadow_addr[tr_chan[i]] = tr_exp_addr[i];
    end
    // written value at the first valid cycle and hold at the end
    if (k == 7 || k == 13) begin
      check_channels();
    end
    if (k == 13) begin
      check_bit("if2rf_cfg_select_mode", if2rf_cfg_select_mode, tr_mode[i]);
    end
  endtask

  task automatic run_entry(input int i);
    int k;
    int k0;
    // a McBSP header enters two edges later in the pipe
    k0 = (tr_kind[i] == kind_mcbsp && tr_clash[i] == 0) ? 2 : 0;
    cur_entry = i;
    for (k = k0 - 1; k <= 13; k++) begin
      cur_k = k;
      if (k >= k0) begin
        check_slot(i, k);
      end
      drive_slot(i, k);
      @(negedge spi_clk_in);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int c;
    sys_rest          = 1'b1;
    rs_rx_data_valid  = 1'b0;
    rs_rx_data        = '0;
    mcbsp_data        = '0;
    mcbsp_data_valid  = 1'b0;
    dsp_rdy_pulse     = 1'b0;
    initial_en        = 1'b0;
    spi_initial_start = 1'b0;
    for (c = 1; c <= 4; c++) begin
      shadow_data[c] = '0;
      shadow_addr[c] = '0;
    end
    load_trace();
    cycle_limit = tr_kind.size() * 16 + 16;
    repeat (16) @(negedge spi_clk_in);
    // idle outputs while reset is held
    cur_entry = -1;
    check_starts("spi_start", starts_now(), 7'h00);
    check_bit("spi_single_en", spi_single_en, 1'b0);
    check_bit("if2rf_cfg_select_mode", if2rf_cfg_select_mode, 1'b0);
    for (c = 1; c <= 4; c++) begin
      check_bit($sformatf("%s_cfg_valid", chan_name(c)), chan_valid(c), 1'b0);
    end
    check_channels();
    sys_rest = 1'b0;
    @(negedge spi_clk_in);
    for (c = 0; c < tr_kind.size(); c++) begin
      run_entry(c);
    end
    if (u_device_wr_process.u_props.fail_cnt != 0) begin
      stop_run("a bound assertion on the DUT outputs failed");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

//--- device_wr_trace.txt
# kind hdr data clash chan exp_data exp_addr starts mode (all numbers hex)
# chan 0 none 1 lmk 2 dac 3 adc 4 if2rf, starts bit n-1 is select n, mode after command
rs    abab0110 11111111 0 1 11111111 10 01 0
rs    abab0221 22222222 0 1 22222222 21 02 0
rs    abab0332 33333333 0 2 33333333 32 04 0
rs    abab0443 44444444 0 3 44444444 43 08 0
rs    abab0554 55555555 0 3 55555555 54 10 0
rs    abab0665 66666666 0 4 66666666 65 20 0
rs    abab0776 77777777 0 4 77777777 76 40 1
rs    abab0687 a5a5a5a5 0 4 a5a5a5a5 87 20 0
mcbsp abab0398 0badf00d 0 2 0badf00d 98 04 0
mcbsp abab05a9 13579bdf 0 3 13579bdf a9 10 0
mcbsp abab07ba deadbeef 0 4 deadbeef ba 40 1
mcbsp abab01cb cafe0001 1 0 00000000 00 00 1
rs    1234025c feedface 0 0 00000000 00 00 1
rs    abab00d1 12121212 0 0 00000000 00 00 0
mcbsp abab07e2 5a5a5a5a 0 4 5a5a5a5a e2 40 1
rs    abab09f3 34343434 0 0 00000000 00 00 0
mcbsp abab0904 56565656 0 0 00000000 00 00 0
rs    abab0115 89abcdef 0 1 89abcdef 15 01 0
init  00000000 00000000 0 0 00000000 00 03 0
dsp   00000000 00000000 0 0 00000000 00 38 0
rs    abab0226 fedcba98 0 1 fedcba98 26 02 0

//--- tb.f
+incdir+.
cfg_dispatch_pkg.sv
cfg_cmd_if.sv
rs_word_splitter.sv
cfg_source_arbiter.sv
cfg_packet_unpacker.sv
cfg_device_router.sv
spi_start_ctrl.sv
device_wr_process.sv
device_wr_process_properties.sv
device_wr_process_tb.sv

//--- Makefile
# Verilator build and run for the device write dispatcher testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = device_wr_process_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
